/* Makefile */
TOP = directory_bank_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* design/directory_bank.sv */
`timescale 1ns/1ns

module directory_bank (
   input  logic              clk
  ,input  logic              rst

  // L2 side
  ,input  logic              l2todr_req_valid
  ,output logic              l2todr_req_retry
  ,input  dr_pkg::l2_req_t   l2todr_req

  ,output logic              drtol2_snack_valid
  ,input  logic              drtol2_snack_retry
  ,output dr_pkg::snack_t    drtol2_snack

  ,input  logic              l2todr_disp_valid
  ,output logic              l2todr_disp_retry
  ,input  dr_pkg::disp_t     l2todr_disp

  ,output logic              drtol2_dack_valid
  ,input  logic              drtol2_dack_retry
  ,output dr_pkg::dack_t     drtol2_dack

  // Memory side
  ,output logic              drtomem_req_valid
  ,input  logic              drtomem_req_retry
  ,output dr_pkg::mem_req_t  drtomem_req

  ,input  logic              memtodr_ack_valid
  ,output logic              memtodr_ack_retry
  ,input  dr_pkg::mem_ack_t  memtodr_ack

  ,output logic              drtomem_wb_valid
  ,input  logic              drtomem_wb_retry
  ,output dr_pkg::wb_t       drtomem_wb
);

  // Table write from the request side
  logic             wr_valid;
  logic             wr_retry;
  dr_pkg::drid_t    wr_drid;
  dr_pkg::req_ids_t wr_ids;

  // Table read from the ack side and its result
  logic             rd_valid;
  logic             rd_retry;
  dr_pkg::drid_t    rd_drid;
  logic             rd_data_valid;
  logic             rd_data_retry;
  dr_pkg::req_ids_t rd_data;

  // DRID handed back to the free vector
  logic             release_valid;
  dr_pkg::drid_t    release_drid;

  dr_req_issue req_issue (
     .clk (clk), .rst (rst)
    ,.l2todr_req_valid  (l2todr_req_valid),  .l2todr_req_retry  (l2todr_req_retry)
    ,.l2todr_req        (l2todr_req)
    ,.drtomem_req_valid (drtomem_req_valid), .drtomem_req_retry (drtomem_req_retry)
    ,.drtomem_req       (drtomem_req)
    ,.wr_valid (wr_valid), .wr_retry (wr_retry), .wr_drid (wr_drid), .wr_ids (wr_ids)
    ,.release_valid (release_valid), .release_drid (release_drid)
  );

  dr_id_table id_table (
     .clk (clk), .rst (rst)
    ,.wr_valid (wr_valid), .wr_retry (wr_retry), .wr_drid (wr_drid), .wr_ids (wr_ids)
    ,.rd_valid (rd_valid), .rd_retry (rd_retry), .rd_drid (rd_drid)
    ,.rd_data_valid (rd_data_valid), .rd_data_retry (rd_data_retry), .rd_data (rd_data)
    ,.release_valid (release_valid), .release_drid (release_drid)
  );

  dr_ack_return ack_return (
     .clk (clk), .rst (rst)
    ,.memtodr_ack_valid  (memtodr_ack_valid),  .memtodr_ack_retry  (memtodr_ack_retry)
    ,.memtodr_ack        (memtodr_ack)
    ,.rd_valid (rd_valid), .rd_retry (rd_retry), .rd_drid (rd_drid)
    ,.rd_data_valid (rd_data_valid), .rd_data_retry (rd_data_retry), .rd_data (rd_data)
    ,.drtol2_snack_valid (drtol2_snack_valid), .drtol2_snack_retry (drtol2_snack_retry)
    ,.drtol2_snack       (drtol2_snack)
  );

  dr_disp_path disp_path (
     .clk (clk), .rst (rst)
    ,.l2todr_disp_valid (l2todr_disp_valid), .l2todr_disp_retry (l2todr_disp_retry)
    ,.l2todr_disp       (l2todr_disp)
    ,.drtomem_wb_valid  (drtomem_wb_valid),  .drtomem_wb_retry  (drtomem_wb_retry)
    ,.drtomem_wb        (drtomem_wb)
    ,.drtol2_dack_valid (drtol2_dack_valid), .drtol2_dack_retry (drtol2_dack_retry)
    ,.drtol2_dack       (drtol2_dack)
  );

endmodule

/* design/dr_ack_return.sv */
`timescale 1ns/1ns

module dr_ack_return (
   input  logic              clk
  ,input  logic              rst

  ,input  logic              memtodr_ack_valid
  ,output logic              memtodr_ack_retry
  ,input  dr_pkg::mem_ack_t  memtodr_ack

  ,output logic              rd_valid
  ,input  logic              rd_retry
  ,output dr_pkg::drid_t     rd_drid

  ,input  logic              rd_data_valid
  ,output logic              rd_data_retry
  ,input  dr_pkg::req_ids_t  rd_data

  ,output logic              drtol2_snack_valid
  ,input  logic              drtol2_snack_retry
  ,output dr_pkg::snack_t    drtol2_snack
);

  logic             ack_in_valid;
  logic             ack_in_retry;
  logic             ack_q_valid;
  logic             ack_q_retry;
  dr_pkg::mem_ack_t ack_q;

  logic             snack_next_valid;
  logic             snack_next_retry;
  dr_pkg::snack_t   snack_next;

  // Fork the ack into its holding stage and a table lookup
  assign memtodr_ack_retry = ack_in_retry || rd_retry;
  assign ack_in_valid      = memtodr_ack_valid && !rd_retry;
  assign rd_valid          = memtodr_ack_valid && !ack_in_retry;
  assign rd_drid           = memtodr_ack.drid;

  // Holds the ack code and line while the table read is in flight
  fluid_flop #(.payload_t(dr_pkg::mem_ack_t)) ack_ff (
     .clk       (clk)
    ,.rst       (rst)
    ,.din_valid (ack_in_valid)
    ,.din_retry (ack_in_retry)
    ,.din       (memtodr_ack)
    ,.q_valid   (ack_q_valid)
    ,.q_retry   (ack_q_retry)
    ,.q         (ack_q)
  );

  // Join, both sides were forked together so their heads always belong to the same ack
  assign snack_next_valid = ack_q_valid && rd_data_valid;
  assign ack_q_retry      = snack_next_retry || !rd_data_valid;
  assign rd_data_retry    = snack_next_retry || !ack_q_valid;

  assign snack_next.nid   = rd_data.nid;
  assign snack_next.l2id  = rd_data.l2id;
  assign snack_next.snack = ack_q.ack;
  assign snack_next.line  = ack_q.line;

  fluid_flop #(.payload_t(dr_pkg::snack_t)) snack_ff (
     .clk       (clk)
    ,.rst       (rst)
    ,.din_valid (snack_next_valid)
    ,.din_retry (snack_next_retry)
    ,.din       (snack_next)
    ,.q_valid   (drtol2_snack_valid)
    ,.q_retry   (drtol2_snack_retry)
    ,.q         (drtol2_snack)
  );

endmodule

/* design/dr_consts.svh */
`ifndef DR_CONSTS_SVH
`define DR_CONSTS_SVH

// Request ids handed out by one directory bank, id 0 never leaves the bank
`define DR_REQIDS     16
`define DR_REQIDBITS  4

// Memory side address and line format
`define DR_PADDRBITS  32
`define DR_LINEBITS   64
`define DR_MASKBITS   8

// Ids that an L2 attaches to its requests
`define DR_NIDBITS    5
`define DR_L2IDBITS   6

// Command and ack code widths
`define DR_CMDBITS    3
`define DR_ACKBITS    3

`endif

/* design/dr_disp_path.sv */
`timescale 1ns/1ns

module dr_disp_path (
   input  logic            clk
  ,input  logic            rst

  ,input  logic            l2todr_disp_valid
  ,output logic            l2todr_disp_retry
  ,input  dr_pkg::disp_t   l2todr_disp

  ,output logic            drtomem_wb_valid
  ,input  logic            drtomem_wb_retry
  ,output dr_pkg::wb_t     drtomem_wb

  ,output logic            drtol2_dack_valid
  ,input  logic            drtol2_dack_retry
  ,output dr_pkg::dack_t   drtol2_dack
);

  logic          has_data;
  logic          wb_next_valid;
  logic          wb_next_retry;
  dr_pkg::wb_t   wb_next;
  logic          dack_next_valid;
  logic          dack_next_retry;
  dr_pkg::dack_t dack_next;

  // Only a displacement that carries a line goes to memory
  assign has_data = l2todr_disp.dcmd != dr_pkg::DCMD_I;

  // Conditional fork, the writeback side drops out when there is no line
  assign l2todr_disp_retry = dack_next_retry || (has_data && wb_next_retry);
  assign wb_next_valid     = l2todr_disp_valid && has_data && !dack_next_retry;
  assign dack_next_valid   = l2todr_disp_valid && (!has_data || !wb_next_retry);

  assign wb_next.paddr = l2todr_disp.paddr;
  assign wb_next.line  = l2todr_disp.line;
  assign wb_next.mask  = l2todr_disp.mask;

  // The dack returns the displacement's own ids
  assign dack_next.nid  = l2todr_disp.nid;
  assign dack_next.l2id = l2todr_disp.l2id;

  fluid_flop #(.payload_t(dr_pkg::wb_t)) wb_ff (
     .clk       (clk)
    ,.rst       (rst)
    ,.din_valid (wb_next_valid)
    ,.din_retry (wb_next_retry)
    ,.din       (wb_next)
    ,.q_valid   (drtomem_wb_valid)
    ,.q_retry   (drtomem_wb_retry)
    ,.q         (drtomem_wb)
  );

  fluid_flop #(.payload_t(dr_pkg::dack_t)) dack_ff (
     .clk       (clk)
    ,.rst       (rst)
    ,.din_valid (dack_next_valid)
    ,.din_retry (dack_next_retry)
    ,.din       (dack_next)
    ,.q_valid   (drtol2_dack_valid)
    ,.q_retry   (drtol2_dack_retry)
    ,.q         (drtol2_dack)
  );

endmodule

/* design/dr_id_table.sv */
`timescale 1ns/1ns
`include "dr_consts.svh"

module dr_id_table (
   input  logic              clk
  ,input  logic              rst

  ,input  logic              wr_valid
  ,output logic              wr_retry
  ,input  dr_pkg::drid_t     wr_drid
  ,input  dr_pkg::req_ids_t  wr_ids

  ,input  logic              rd_valid
  ,output logic              rd_retry
  ,input  dr_pkg::drid_t     rd_drid

  ,output logic              rd_data_valid
  ,input  logic              rd_data_retry
  ,output dr_pkg::req_ids_t  rd_data

  ,output logic              release_valid
  ,output dr_pkg::drid_t     release_drid
);

  // Node id and L2 id of each outstanding request, indexed by DRID
  dr_pkg::req_ids_t ids_mem [`DR_REQIDS];

  // Arbiter state, low while reads are preferred
  logic pref_write;

  logic out_ready;
  logic rd_accept;
  logic wr_accept;

  // The read data register can take a new read when empty or draining
  assign out_ready = !rd_data_valid || !rd_data_retry;

  // Read loses to a write in the write-preferred state, and also waits on its output register
  assign rd_retry = (wr_valid && pref_write) || !out_ready;

  // A write loses only to a read that can actually go this cycle
  assign wr_retry = rd_valid && !pref_write && out_ready;

  assign rd_accept = rd_valid && !rd_retry;
  assign wr_accept = wr_valid && !wr_retry;

  // The DRID is free again once its ids have been read out
  assign release_valid = rd_accept;
  assign release_drid  = rd_drid;

  // Preference flips to the other side after each granted operation
  always_ff @(posedge clk) begin
    if (rst) begin
      pref_write <= 1'b0;
    end else if (rd_accept) begin
      pref_write <= 1'b1;
    end else if (wr_accept) begin
      pref_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      ids_mem[wr_drid] <= wr_ids;
    end
  end

  // Read result stays put while the consumer retries
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_valid <= 1'b0;
    end else if (out_ready) begin
      rd_data_valid <= rd_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_data <= ids_mem[rd_drid];
    end
  end

endmodule

/* design/dr_pkg.sv */
package dr_pkg;

`include "dr_consts.svh"

  typedef logic [`DR_REQIDBITS-1:0] drid_t;

  // DCMD_I carries no line, every other code is written back
  typedef enum logic [1:0] {
    DCMD_I = 2'b00,
    DCMD_S = 2'b01,
    DCMD_E = 2'b10,
    DCMD_M = 2'b11
  } dcmd_e;

  typedef struct packed {
    logic [`DR_PADDRBITS-1:0] paddr;
    logic [`DR_CMDBITS-1:0]   cmd;
    logic [`DR_NIDBITS-1:0]   nid;
    logic [`DR_L2IDBITS-1:0]  l2id;
  } l2_req_t;

  // Memory only sees the DRID, the L2 ids stay in the bank
  typedef struct packed {
    logic [`DR_PADDRBITS-1:0] paddr;
    logic [`DR_CMDBITS-1:0]   cmd;
    drid_t                    drid;
  } mem_req_t;

  typedef struct packed {
    drid_t                   drid;
    logic [`DR_ACKBITS-1:0]  ack;
    logic [`DR_LINEBITS-1:0] line;
  } mem_ack_t;

  typedef struct packed {
    logic [`DR_NIDBITS-1:0]  nid;
    logic [`DR_L2IDBITS-1:0] l2id;
    logic [`DR_ACKBITS-1:0]  snack;
    logic [`DR_LINEBITS-1:0] line;
  } snack_t;

  typedef struct packed {
    logic [`DR_PADDRBITS-1:0] paddr;
    logic [`DR_LINEBITS-1:0]  line;
    logic [`DR_MASKBITS-1:0]  mask;
    dcmd_e                    dcmd;
    logic [`DR_NIDBITS-1:0]   nid;
    logic [`DR_L2IDBITS-1:0]  l2id;
  } disp_t;

  typedef struct packed {
    logic [`DR_PADDRBITS-1:0] paddr;
    logic [`DR_LINEBITS-1:0]  line;
    logic [`DR_MASKBITS-1:0]  mask;
  } wb_t;

  typedef struct packed {
    logic [`DR_NIDBITS-1:0]  nid;
    logic [`DR_L2IDBITS-1:0] l2id;
  } dack_t;

  // One entry of the id table, same layout as a dack
  typedef struct packed {
    logic [`DR_NIDBITS-1:0]  nid;
    logic [`DR_L2IDBITS-1:0] l2id;
  } req_ids_t;

endpackage

/* design/dr_req_issue.sv */
`timescale 1ns/1ns
`include "dr_consts.svh"

module dr_req_issue (
   input  logic              clk
  ,input  logic              rst

  ,input  logic              l2todr_req_valid
  ,output logic              l2todr_req_retry
  ,input  dr_pkg::l2_req_t   l2todr_req

  ,output logic              drtomem_req_valid
  ,input  logic              drtomem_req_retry
  ,output dr_pkg::mem_req_t  drtomem_req

  ,output logic              wr_valid
  ,input  logic              wr_retry
  ,output dr_pkg::drid_t     wr_drid
  ,output dr_pkg::req_ids_t  wr_ids

  ,input  logic              release_valid
  ,input  dr_pkg::drid_t     release_drid
);

  // One bit per DRID, set while the DRID is free
  logic [`DR_REQIDS-1:0] free_vec;
  dr_pkg::drid_t         free_drid;
  logic                  drid_avail;

  dr_pkg::mem_req_t      mem_req_next;
  logic                  mem_req_next_valid;
  logic                  mem_req_next_retry;
  logic                  req_accept;

  // Priority encoder, scanning down so the lowest free DRID wins
  // Bit 0 is skipped since DRID 0 is reserved
  always_comb begin
    free_drid  = '0;
    drid_avail = 1'b0;
    for (int i = `DR_REQIDS - 1; i > 0; i--) begin
      if (free_vec[i]) begin
        free_drid  = dr_pkg::drid_t'(i);
        drid_avail = 1'b1;
      end
    end
  end

  // Fork of the request into the memory stage and the table write
  // Each side only sees valid when the other side can take it too
  assign l2todr_req_retry   = !drid_avail || mem_req_next_retry || wr_retry;
  assign mem_req_next_valid = l2todr_req_valid && drid_avail && !wr_retry;
  assign wr_valid           = l2todr_req_valid && drid_avail && !mem_req_next_retry;
  assign req_accept         = l2todr_req_valid && !l2todr_req_retry;

  // Memory gets the DRID in place of the L2 ids
  assign mem_req_next.paddr = l2todr_req.paddr;
  assign mem_req_next.cmd   = l2todr_req.cmd;
  assign mem_req_next.drid  = free_drid;

  assign wr_drid     = free_drid;
  assign wr_ids.nid  = l2todr_req.nid;
  assign wr_ids.l2id = l2todr_req.l2id;

  // Allocated and released DRIDs never collide, one is free and the other busy
  always_ff @(posedge clk) begin
    if (rst) begin
      free_vec <= {{(`DR_REQIDS-1){1'b1}}, 1'b0};
    end else begin
      if (req_accept) begin
        free_vec[free_drid] <= 1'b0;
      end
      if (release_valid) begin
        free_vec[release_drid] <= 1'b1;
      end
    end
  end

  fluid_flop #(.payload_t(dr_pkg::mem_req_t)) mem_req_ff (
     .clk       (clk)
    ,.rst       (rst)
    ,.din_valid (mem_req_next_valid)
    ,.din_retry (mem_req_next_retry)
    ,.din       (mem_req_next)
    ,.q_valid   (drtomem_req_valid)
    ,.q_retry   (drtomem_req_retry)
    ,.q         (drtomem_req)
  );

endmodule

/* design/fluid_flop.sv */
`timescale 1ns/1ns

module fluid_flop #(
  parameter type payload_t = logic
) (
   input  logic     clk
  ,input  logic     rst

  ,input  logic     din_valid
  ,output logic     din_retry
  ,input  payload_t din

  ,output logic     q_valid
  ,input  logic     q_retry
  ,output payload_t q
);

  // Second entry catches the item that arrives while q is stalled
  logic     skid_valid;
  payload_t skid;
  logic     q_free;

  // The input only stalls once both entries hold data, so retry is a pure flop output
  assign din_retry = skid_valid;

  // Output register takes a new item when empty or when its item leaves this cycle
  assign q_free = !q_valid || !q_retry;

  always_ff @(posedge clk) begin
    if (rst) begin
      q_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (q_free) begin
      // Skid drains first, which keeps the items in order
      q_valid    <= skid_valid || din_valid;
      skid_valid <= 1'b0;
    end else if (din_valid && !skid_valid) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (q_free) begin
      q <= skid_valid ? skid : din;
    end
    if (!q_free && !skid_valid) begin
      skid <= din;
    end
  end

endmodule

/* list.f */
+incdir+design
design/dr_pkg.sv
design/fluid_flop.sv
design/dr_req_issue.sv
design/dr_id_table.sv
design/dr_ack_return.sv
design/dr_disp_path.sv
design/directory_bank.sv
tb/tb_clock.sv
tb/directory_bank_properties.sv
tb/directory_bank_tb.sv

/* tb/directory_bank_properties.sv */
`timescale 1ns/1ns

module directory_bank_properties (
   input logic              clk
  ,input logic              rst
  ,input logic              drtomem_req_valid
  ,input logic              drtomem_req_retry
  ,input dr_pkg::mem_req_t  drtomem_req
  ,input logic              drtol2_snack_valid
  ,input logic              drtol2_snack_retry
  ,input dr_pkg::snack_t    drtol2_snack
  ,input logic              drtomem_wb_valid
  ,input logic              drtomem_wb_retry
  ,input dr_pkg::wb_t       drtomem_wb
  ,input logic              drtol2_dack_valid
  ,input logic              drtol2_dack_retry
  ,input dr_pkg::dack_t     drtol2_dack
);

  // Counts failed assertions so the testbench can see them at the end
  int unsigned assert_fails = 0;

  // A stalled output keeps both its valid and its payload until the transfer
  mem_req_held: assert property (@(posedge clk) disable iff (rst)
    drtomem_req_valid && drtomem_req_retry |=> drtomem_req_valid && $stable(drtomem_req))
    else begin
      $error("drtomem_req changed while retried");
      assert_fails++;
    end

  snack_held: assert property (@(posedge clk) disable iff (rst)
    drtol2_snack_valid && drtol2_snack_retry |=> drtol2_snack_valid && $stable(drtol2_snack))
    else begin
      $error("drtol2_snack changed while retried");
      assert_fails++;
    end

  wb_held: assert property (@(posedge clk) disable iff (rst)
    drtomem_wb_valid && drtomem_wb_retry |=> drtomem_wb_valid && $stable(drtomem_wb))
    else begin
      $error("drtomem_wb changed while retried");
      assert_fails++;
    end

  dack_held: assert property (@(posedge clk) disable iff (rst)
    drtol2_dack_valid && drtol2_dack_retry |=> drtol2_dack_valid && $stable(drtol2_dack))
    else begin
      $error("drtol2_dack changed while retried");
      assert_fails++;
    end

  // DRID 0 stays inside the bank
  drid_nonzero: assert property (@(posedge clk) disable iff (rst)
    drtomem_req_valid |-> drtomem_req.drid != '0)
    else begin
      $error("drtomem_req carries DRID 0");
      assert_fails++;
    end

  // Once reset has been seen for a full cycle every output valid is low
  quiet_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |->
      !(drtomem_req_valid || drtol2_snack_valid || drtomem_wb_valid || drtol2_dack_valid))
    else begin
      $error("an output valid is high during reset");
      assert_fails++;
    end

endmodule

/* tb/directory_bank_tb.sv */
`timescale 1ns/1ns
`include "dr_consts.svh"

module directory_bank_tb;

  logic              clk;
  logic              rst;

  logic              l2todr_req_valid = 1'b0;
  logic              l2todr_req_retry;
  dr_pkg::l2_req_t   l2todr_req = '0;
  logic              drtol2_snack_valid;
  logic              drtol2_snack_retry = 1'b0;
  dr_pkg::snack_t    drtol2_snack;
  logic              l2todr_disp_valid = 1'b0;
  logic              l2todr_disp_retry;
  dr_pkg::disp_t     l2todr_disp = '0;
  logic              drtol2_dack_valid;
  logic              drtol2_dack_retry = 1'b0;
  dr_pkg::dack_t     drtol2_dack;
  logic              drtomem_req_valid;
  logic              drtomem_req_retry = 1'b0;
  dr_pkg::mem_req_t  drtomem_req;
  logic              memtodr_ack_valid = 1'b0;
  logic              memtodr_ack_retry;
  dr_pkg::mem_ack_t  memtodr_ack = '0;
  logic              drtomem_wb_valid;
  logic              drtomem_wb_retry = 1'b0;
  dr_pkg::wb_t       drtomem_wb;

  int seed = 57;

  // Traffic targets come from the test sequence while the driver keeps the issued counts
  int req_target  = 0;
  int disp_target = 0;
  int ack_target  = 0;
  bit retry_on    = 1'b0;
  int req_issued  = 0;
  int disp_issued = 0;
  int ack_issued  = 0;

  // Reference model state
  bit               model_free [`DR_REQIDS];
  dr_pkg::req_ids_t id_map [`DR_REQIDS];
  dr_pkg::mem_req_t exp_mem_q[$];
  dr_pkg::snack_t   exp_snack_q[$];
  dr_pkg::wb_t      exp_wb_q[$];
  dr_pkg::dack_t    exp_dack_q[$];
  // DRIDs that memory has seen and not yet acked
  dr_pkg::drid_t    pending[$];
  int               req_accepted = 0;

  tb_clock clk_gen (.clk(clk), .rst(rst));

  directory_bank dut0 (.*);

  bind directory_bank directory_bank_properties props0 (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_mem_req(input dr_pkg::mem_req_t got, input dr_pkg::mem_req_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED drtomem_req got %h expected %h", got, exp));
    end
  endtask

  task automatic check_snack(input dr_pkg::snack_t got, input dr_pkg::snack_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED drtol2_snack got %h expected %h", got, exp));
    end
  endtask

  task automatic check_wb(input dr_pkg::wb_t got, input dr_pkg::wb_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED drtomem_wb got %h expected %h", got, exp));
    end
  endtask

  task automatic check_dack(input dr_pkg::dack_t got, input dr_pkg::dack_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED drtol2_dack got %h expected %h", got, exp));
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic bit chance(input int unsigned pct);
    return (rand32() % 32'd100) < pct;
  endfunction

  // Lowest free DRID above the reserved 0, and 0 when the bank is full
  function automatic dr_pkg::drid_t lowest_free();
    for (int i = 1; i < `DR_REQIDS; i++) begin
      if (model_free[i]) return dr_pkg::drid_t'(i);
    end
    return '0;
  endfunction

  function automatic bit traffic_drained();
    return req_issued == req_target && disp_issued == disp_target &&
           !l2todr_req_valid && !l2todr_disp_valid && !memtodr_ack_valid &&
           exp_mem_q.size() == 0 && pending.size() == 0 &&
           exp_snack_q.size() == 0 && exp_wb_q.size() == 0 && exp_dack_q.size() == 0;
  endfunction

  // Input transfers seen at this edge turn into expected outputs
  task automatic observe_inputs();
    dr_pkg::drid_t    d;
    dr_pkg::mem_req_t m;
    dr_pkg::snack_t   s;
    dr_pkg::wb_t      w;
    dr_pkg::dack_t    k;
    // The request side allocates from the free set as it was before this edge's release
    if (l2todr_req_valid && !l2todr_req_retry) begin
      d = lowest_free();
      if (d == '0) report_failure("a request was accepted while no DRID was free");
      m.paddr = l2todr_req.paddr;
      m.cmd   = l2todr_req.cmd;
      m.drid  = d;
      exp_mem_q.push_back(m);
      model_free[d]   = 1'b0;
      id_map[d].nid   = l2todr_req.nid;
      id_map[d].l2id  = l2todr_req.l2id;
      req_accepted++;
    end
    if (memtodr_ack_valid && !memtodr_ack_retry) begin
      d = memtodr_ack.drid;
      s.nid   = id_map[d].nid;
      s.l2id  = id_map[d].l2id;
      s.snack = memtodr_ack.ack;
      s.line  = memtodr_ack.line;
      exp_snack_q.push_back(s);
      model_free[d] = 1'b1;
    end
    if (l2todr_disp_valid && !l2todr_disp_retry) begin
      k.nid  = l2todr_disp.nid;
      k.l2id = l2todr_disp.l2id;
      exp_dack_q.push_back(k);
      if (l2todr_disp.dcmd != dr_pkg::DCMD_I) begin
        w.paddr = l2todr_disp.paddr;
        w.line  = l2todr_disp.line;
        w.mask  = l2todr_disp.mask;
        exp_wb_q.push_back(w);
      end
    end
  endtask

  task automatic observe_outputs();
    if (drtomem_req_valid && !drtomem_req_retry) begin
      if (exp_mem_q.size() == 0) begin
        report_failure("memory request appeared with no L2 request behind it");
      end else begin
        check_mem_req(drtomem_req, exp_mem_q.pop_front());
        pending.push_back(drtomem_req.drid);
      end
    end
    if (drtol2_snack_valid && !drtol2_snack_retry) begin
      if (exp_snack_q.size() == 0) begin
        report_failure("snack appeared with no memory ack behind it");
      end else begin
        check_snack(drtol2_snack, exp_snack_q.pop_front());
      end
    end
    if (drtomem_wb_valid && !drtomem_wb_retry) begin
      if (exp_wb_q.size() == 0) begin
        report_failure("writeback appeared with no data displacement behind it");
      end else begin
        check_wb(drtomem_wb, exp_wb_q.pop_front());
      end
    end
    if (drtol2_dack_valid && !drtol2_dack_retry) begin
      if (exp_dack_q.size() == 0) begin
        report_failure("dack appeared with no displacement behind it");
      end else begin
        check_dack(drtol2_dack, exp_dack_q.pop_front());
      end
    end
  endtask

  // New items only replace an input once the previous one has transferred
  task automatic drive_inputs();
    dr_pkg::l2_req_t  r;
    dr_pkg::disp_t    p;
    dr_pkg::mem_ack_t a;
    logic [31:0]      tmp;
    int               idx;
    if (!l2todr_req_valid || !l2todr_req_retry) begin
      if (req_issued < req_target && chance(70)) begin
        tmp     = rand32();
        r.paddr = rand32();
        r.cmd   = tmp[2:0];
        r.nid   = tmp[7:3];
        r.l2id  = tmp[13:8];
        l2todr_req       <= r;
        l2todr_req_valid <= 1'b1;
        req_issued++;
      end else begin
        l2todr_req_valid <= 1'b0;
      end
    end
    if (!l2todr_disp_valid || !l2todr_disp_retry) begin
      if (disp_issued < disp_target && chance(60)) begin
        tmp     = rand32();
        p.paddr = rand32();
        p.line  = {rand32(), rand32()};
        p.mask  = tmp[7:0];
        p.dcmd  = dr_pkg::dcmd_e'(tmp[9:8]);
        p.nid   = tmp[14:10];
        p.l2id  = tmp[20:15];
        l2todr_disp       <= p;
        l2todr_disp_valid <= 1'b1;
        disp_issued++;
      end else begin
        l2todr_disp_valid <= 1'b0;
      end
    end
    // Memory model acks an outstanding DRID picked at random
    if (!memtodr_ack_valid || !memtodr_ack_retry) begin
      if (ack_issued < ack_target && pending.size() > 0 && chance(50)) begin
        idx    = int'(rand32() % pending.size());
        tmp    = rand32();
        a.drid = pending[idx];
        a.ack  = tmp[2:0];
        a.line = {rand32(), rand32()};
        pending.delete(idx);
        memtodr_ack       <= a;
        memtodr_ack_valid <= 1'b1;
        ack_issued++;
      end else begin
        memtodr_ack_valid <= 1'b0;
      end
    end
    drtomem_req_retry  <= retry_on && chance(30);
    drtol2_snack_retry <= retry_on && chance(30);
    drtomem_wb_retry   <= retry_on && chance(30);
    drtol2_dack_retry  <= retry_on && chance(30);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      l2todr_req_valid   <= 1'b0;
      l2todr_disp_valid  <= 1'b0;
      memtodr_ack_valid  <= 1'b0;
      drtomem_req_retry  <= 1'b0;
      drtol2_snack_retry <= 1'b0;
      drtomem_wb_retry   <= 1'b0;
      drtol2_dack_retry  <= 1'b0;
      for (int i = 0; i < `DR_REQIDS; i++) begin
        model_free[i] = (i != 0);
      end
    end else begin
      observe_inputs();
      observe_outputs();
      drive_inputs();
    end
  end

  // The test sequence samples on the falling edge in all its waits
  initial begin
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 100) report_failure("timeout waiting for reset to be released");
    end while (rst);

    // Fill every DRID with no acks returned
    req_target = 16;
    cycles = 0;
    while (req_accepted < 15) begin
      @(negedge clk);
      cycles++;
      if (cycles > 400) report_failure("timeout waiting for 15 accepted requests");
    end
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (!l2todr_req_retry || req_accepted != 15) begin
        report_failure("request path took more than 15 requests with no ack returned");
      end
    end

    // One ack frees one DRID and the waiting request takes it
    ack_target = 1;
    cycles = 0;
    while (req_accepted < 16 || exp_mem_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 400) report_failure("timeout waiting for the request after the first ack");
    end

    // Mixed random traffic under random back-pressure
    retry_on    = 1'b1;
    req_target  = 316;
    disp_target = 200;
    ack_target  = 100000;
    cycles = 0;
    while (!traffic_drained()) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20000) report_failure("timeout waiting for all traffic to drain");
    end
    // A few idle cycles so a duplicated output would still be caught
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
    end

    if (dut0.props0.assert_fails != 0) begin
      report_failure("handshake assertions failed during the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
   output logic clk
  ,output logic rst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset spans the first 16 rising edges and drops on the last of them
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
